//--- Makefile
# Verilator build and run for the control-register testbench

VERILATOR ?= verilator
FILELIST  ?= src.f
TOP       ?= tb_cr_top
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SRCS := $(filter %.sv %.v,$(shell cat $(FILELIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# Exit status of the binary is the pass/fail result
run: $(BIN)
	./$(BIN)

clean:
	rm -rf $(OBJ_DIR)

//--- cr_mem.sv
// Control registers shared by the core and the fabric; board I/O staging and keyboard pop
`timescale 1ns/1ns

module cr_mem (
    input  logic                            Clk,
    input  logic                            arst_n,

    // Core word port
    input  logic [cr_pkg::CR_DATA_W-1:0]    address,
    input  logic [cr_pkg::CR_DATA_W-1:0]    data,
    input  logic                            wren,
    input  logic                            rden,
    output logic [cr_pkg::CR_DATA_W-1:0]    q,

    // Fabric read port
    input  logic [cr_pkg::CR_DATA_W-1:0]    address_b,
    output logic [cr_pkg::CR_DATA_W-1:0]    q_b,

    // Raster position
    input  logic [cr_pkg::VGA_POS_W-1:0]    vga_x,
    input  logic [cr_pkg::VGA_POS_W-1:0]    vga_y,

    // Board inputs, asynchronous to Clk
    input  logic                            button_0,
    input  logic                            button_1,
    input  logic [cr_pkg::SWITCH_W-1:0]     switch,
    input  logic [cr_pkg::JOY_W-1:0]        joystick_x,
    input  logic [cr_pkg::JOY_W-1:0]        joystick_y,

    // Keyboard queue
    input  logic                            kbd_nonempty,
    input  logic [cr_pkg::KBD_CODE_W-1:0]   kbd_head,
    output logic                            kbd_pop,
    output logic                            kbd_scanf_en,

    // Display pins
    output logic [cr_pkg::SEG7_W-1:0]       seg7_0,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_1,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_2,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_3,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_4,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_5,
    output logic [cr_pkg::LED_W-1:0]        led
);
    import cr_pkg::*;

    // Core-written display registers, then the middle output stage
    logic [SEG7_W-1:0]      seg7_wr [6];
    logic [SEG7_W-1:0]      seg7_p1 [6];
    logic [LED_W-1:0]       led_wr;
    logic [LED_W-1:0]       led_p1;

    // Synchronizer flops, s2 is the one read back
    logic                   button_0_s1, button_0_s2;
    logic                   button_1_s1, button_1_s2;
    logic [SWITCH_W-1:0]    switch_s1, switch_s2;
    logic [JOY_W-1:0]       joy_x_s1, joy_x_s2;
    logic [JOY_W-1:0]       joy_y_s1, joy_y_s2;

    // Raster sampled once
    logic [VGA_POS_W-1:0]   vga_x_r;
    logic [VGA_POS_W-1:0]   vga_y_r;

    logic [CR_DATA_W-1:0]   pre_q;
    logic [CR_DATA_W-1:0]   pre_q_b;

    // Read mux shared by both ports, every field zero-extended
    function automatic logic [CR_DATA_W-1:0] read_mux(input logic [CR_DATA_W-1:0] addr);
        logic [CR_DATA_W-1:0] word;
        word = '0;
        case (cr_addr_e'(addr))
            // Output registers read at the pin stage
            CR_SEG7_0       : word = CR_DATA_W'(seg7_0);
            CR_SEG7_1       : word = CR_DATA_W'(seg7_1);
            CR_SEG7_2       : word = CR_DATA_W'(seg7_2);
            CR_SEG7_3       : word = CR_DATA_W'(seg7_3);
            CR_SEG7_4       : word = CR_DATA_W'(seg7_4);
            CR_SEG7_5       : word = CR_DATA_W'(seg7_5);
            CR_LED          : word = CR_DATA_W'(led);
            CR_KBD_SCANF_EN : word = CR_DATA_W'(kbd_scanf_en);
            // Read-only board state
            CR_BUTTON_0     : word = CR_DATA_W'(button_0_s2);
            CR_BUTTON_1     : word = CR_DATA_W'(button_1_s2);
            CR_SWITCH       : word = CR_DATA_W'(switch_s2);
            CR_JOYSTICK_X   : word = CR_DATA_W'(joy_x_s2);
            CR_JOYSTICK_Y   : word = CR_DATA_W'(joy_y_s2);
            CR_KBD_READY    : word = CR_DATA_W'(kbd_nonempty);
            // Head is already zero when the queue is empty
            CR_KBD_DATA     : word = CR_DATA_W'(kbd_head);
            CR_VGA_X        : word = CR_DATA_W'(vga_x_r);
            CR_VGA_Y        : word = CR_DATA_W'(vga_y_r);
            default         : word = '0;
        endcase
        return word;
    endfunction

    // ----------------------------------------------------------------------
    // Core write decode
    // ----------------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            seg7_wr      <= '{default: '0};
            led_wr       <= '0;
            kbd_scanf_en <= 1'b0;
        end else if (wren) begin
            case (cr_addr_e'(address))
                CR_SEG7_0       : seg7_wr[0]   <= data[SEG7_W-1:0];
                CR_SEG7_1       : seg7_wr[1]   <= data[SEG7_W-1:0];
                CR_SEG7_2       : seg7_wr[2]   <= data[SEG7_W-1:0];
                CR_SEG7_3       : seg7_wr[3]   <= data[SEG7_W-1:0];
                CR_SEG7_4       : seg7_wr[4]   <= data[SEG7_W-1:0];
                CR_SEG7_5       : seg7_wr[5]   <= data[SEG7_W-1:0];
                CR_LED          : led_wr       <= data[LED_W-1:0];
                CR_KBD_SCANF_EN : kbd_scanf_en <= data[0];
                // Read-only and unmapped offsets drop the write
                default         : ;
            endcase
        end
    end

    // ----------------------------------------------------------------------
    // Output stages, inputs synchronizer, raster sample
    // ----------------------------------------------------------------------
    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            seg7_p1     <= '{default: '0};
            led_p1      <= '0;
            seg7_0      <= '0;
            seg7_1      <= '0;
            seg7_2      <= '0;
            seg7_3      <= '0;
            seg7_4      <= '0;
            seg7_5      <= '0;
            led         <= '0;
            button_0_s1 <= 1'b0;
            button_0_s2 <= 1'b0;
            button_1_s1 <= 1'b0;
            button_1_s2 <= 1'b0;
            switch_s1   <= '0;
            switch_s2   <= '0;
            joy_x_s1    <= '0;
            joy_x_s2    <= '0;
            joy_y_s1    <= '0;
            joy_y_s2    <= '0;
            vga_x_r     <= '0;
            vga_y_r     <= '0;
        end else begin
            // Register -> p1 -> pin
            seg7_p1     <= seg7_wr;
            led_p1      <= led_wr;
            seg7_0      <= seg7_p1[0];
            seg7_1      <= seg7_p1[1];
            seg7_2      <= seg7_p1[2];
            seg7_3      <= seg7_p1[3];
            seg7_4      <= seg7_p1[4];
            seg7_5      <= seg7_p1[5];
            led         <= led_p1;
            // Two flops per board input
            button_0_s1 <= button_0;
            button_0_s2 <= button_0_s1;
            button_1_s1 <= button_1;
            button_1_s2 <= button_1_s1;
            switch_s1   <= switch;
            switch_s2   <= switch_s1;
            joy_x_s1    <= joystick_x;
            joy_x_s2    <= joy_x_s1;
            joy_y_s1    <= joystick_y;
            joy_y_s2    <= joy_y_s1;
            vga_x_r     <= vga_x;
            vga_y_r     <= vga_y;
        end
    end

    // ----------------------------------------------------------------------
    // Read ports
    // ----------------------------------------------------------------------

    // Core result is zero unless rden, fabric reads every cycle
    always_comb begin
        pre_q   = rden ? read_mux(address) : '0;
        pre_q_b = read_mux(address_b);
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            q   <= '0;
            q_b <= '0;
        end else begin
            q   <= pre_q;
            q_b <= pre_q_b;
        end
    end

    // Only a core data read pops, never the fabric
    assign kbd_pop = rden && (address == CR_KBD_DATA) && kbd_nonempty;

endmodule

//--- cr_pkg.sv
// Shared widths and register offsets for the control-register block; import into RTL and testbench
package cr_pkg;

    // ----------------------------------------------------------------------
    // Word and field widths
    // ----------------------------------------------------------------------

    // Core and fabric word size, also the address width
    parameter int CR_DATA_W  = 32;

    // Raw segment pattern per digit
    parameter int SEG7_W     = 8;
    parameter int LED_W      = 10;
    parameter int SWITCH_W   = 10;

    // Joystick ADC sample
    parameter int JOY_W      = 12;

    // PS/2 scan code
    parameter int KBD_CODE_W = 8;

    // Raster position, covers 800 columns and 525 lines
    parameter int VGA_POS_W  = 10;

    // ----------------------------------------------------------------------
    // Register map, byte offsets
    // ----------------------------------------------------------------------

    typedef enum logic [CR_DATA_W-1:0] {
        // Read/write, core side
        CR_SEG7_0       = 32'h0000_0000,
        CR_SEG7_1       = 32'h0000_0004,
        CR_SEG7_2       = 32'h0000_0008,
        CR_SEG7_3       = 32'h0000_000C,
        CR_SEG7_4       = 32'h0000_0010,
        CR_SEG7_5       = 32'h0000_0014,
        CR_LED          = 32'h0000_0018,
        CR_KBD_SCANF_EN = 32'h0000_001C,
        // Read-only, board side
        CR_BUTTON_0     = 32'h0000_0020,
        CR_BUTTON_1     = 32'h0000_0024,
        CR_SWITCH       = 32'h0000_0028,
        CR_JOYSTICK_X   = 32'h0000_002C,
        CR_JOYSTICK_Y   = 32'h0000_0030,
        CR_KBD_READY    = 32'h0000_0034,
        // Core read of this one pops the queue
        CR_KBD_DATA     = 32'h0000_0038,
        CR_VGA_X        = 32'h0000_003C,
        CR_VGA_Y        = 32'h0000_0040
    } cr_addr_e;

endpackage

//--- cr_top.sv
// Board-level control-register subsystem; connects the register block, keyboard queue and raster counter
`timescale 1ns/1ns

module cr_top #(
    parameter int KBD_DEPTH = 4,
    parameter int H_TOTAL   = 800,
    parameter int V_TOTAL   = 525
) (
    input  logic                            Clk,
    input  logic                            arst_n,

    // Core word port
    input  logic [cr_pkg::CR_DATA_W-1:0]    address,
    input  logic [cr_pkg::CR_DATA_W-1:0]    data,
    input  logic                            wren,
    input  logic                            rden,
    output logic [cr_pkg::CR_DATA_W-1:0]    q,

    // Fabric read port
    input  logic [cr_pkg::CR_DATA_W-1:0]    address_b,
    output logic [cr_pkg::CR_DATA_W-1:0]    q_b,

    // Board inputs
    input  logic                            button_0,
    input  logic                            button_1,
    input  logic [cr_pkg::SWITCH_W-1:0]     switch,
    input  logic [cr_pkg::JOY_W-1:0]        joystick_x,
    input  logic [cr_pkg::JOY_W-1:0]        joystick_y,

    // Scan-code stream
    input  logic [cr_pkg::KBD_CODE_W-1:0]   kbd_code,
    input  logic                            kbd_valid,
    output logic                            kbd_in_ready,

    // Pins
    output logic [cr_pkg::SEG7_W-1:0]       seg7_0,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_1,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_2,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_3,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_4,
    output logic [cr_pkg::SEG7_W-1:0]       seg7_5,
    output logic [cr_pkg::LED_W-1:0]        led,
    output logic                            hsync,
    output logic                            vsync
);
    import cr_pkg::*;

    logic [VGA_POS_W-1:0]   vga_x;
    logic [VGA_POS_W-1:0]   vga_y;
    logic                   kbd_nonempty;
    logic [KBD_CODE_W-1:0]  kbd_head;
    logic                   kbd_pop;
    logic                   kbd_scanf_en;

    cr_mem cr_mem_inst (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .address      (address),
        .data         (data),
        .wren         (wren),
        .rden         (rden),
        .q            (q),
        .address_b    (address_b),
        .q_b          (q_b),
        .vga_x        (vga_x),
        .vga_y        (vga_y),
        .button_0     (button_0),
        .button_1     (button_1),
        .switch       (switch),
        .joystick_x   (joystick_x),
        .joystick_y   (joystick_y),
        .kbd_nonempty (kbd_nonempty),
        .kbd_head     (kbd_head),
        .kbd_pop      (kbd_pop),
        .kbd_scanf_en (kbd_scanf_en),
        .seg7_0       (seg7_0),
        .seg7_1       (seg7_1),
        .seg7_2       (seg7_2),
        .seg7_3       (seg7_3),
        .seg7_4       (seg7_4),
        .seg7_5       (seg7_5),
        .led          (led)
    );

    // Queue steered by the register block
    kbd_fifo #(
        .KBD_DEPTH (KBD_DEPTH)
    ) kbd_fifo_inst (
        .Clk          (Clk),
        .arst_n       (arst_n),
        .kbd_code     (kbd_code),
        .kbd_valid    (kbd_valid),
        .kbd_in_ready (kbd_in_ready),
        .kbd_scanf_en (kbd_scanf_en),
        .kbd_pop      (kbd_pop),
        .kbd_nonempty (kbd_nonempty),
        .kbd_head     (kbd_head)
    );

    vga_counter #(
        .H_TOTAL (H_TOTAL),
        .V_TOTAL (V_TOTAL)
    ) vga_counter_inst (
        .Clk    (Clk),
        .arst_n (arst_n),
        .vga_x  (vga_x),
        .vga_y  (vga_y),
        .hsync  (hsync),
        .vsync  (vsync)
    );

endmodule

//--- kbd_fifo.sv
// Scan-code queue between the PS/2 side and the control registers; push by valid/ready, pop by core read
`timescale 1ns/1ns

module kbd_fifo #(
    parameter int KBD_DEPTH = 4
) (
    input  logic                            Clk,
    input  logic                            arst_n,
    input  logic [cr_pkg::KBD_CODE_W-1:0]   kbd_code,
    input  logic                            kbd_valid,
    output logic                            kbd_in_ready,
    input  logic                            kbd_scanf_en,
    input  logic                            kbd_pop,
    output logic                            kbd_nonempty,
    output logic [cr_pkg::KBD_CODE_W-1:0]   kbd_head
);
    import cr_pkg::*;

    localparam int PTR_W = $clog2(KBD_DEPTH);
    localparam int CNT_W = $clog2(KBD_DEPTH + 1);

    // Storage, pointers wrap on their own at a power-of-two depth
    logic [KBD_CODE_W-1:0]  mem [KBD_DEPTH];
    logic [PTR_W-1:0]       wr_ptr;
    logic [PTR_W-1:0]       rd_ptr;
    logic [CNT_W-1:0]       count;
    logic                   full;
    logic                   push;
    logic                   pop;

    assign full         = (count == CNT_W'(KBD_DEPTH));
    assign kbd_nonempty = (count != '0);

    // Gate on enable only at the input, queued codes stay after disable
    assign kbd_in_ready = kbd_scanf_en && !full;
    assign push         = kbd_valid && kbd_in_ready;
    assign pop          = kbd_pop && kbd_nonempty;

    // Zero head when empty so a data read returns 0
    assign kbd_head = kbd_nonempty ? mem[rd_ptr] : '0;

    always_ff @(posedge Clk) begin
        if (push) begin
            mem[wr_ptr] <= kbd_code;
        end
    end

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            // Push and pop together leave the count alone
            case ({push, pop})
                2'b10   : count <= count + 1'b1;
                2'b01   : count <= count - 1'b1;
                default : ;
            endcase
        end
    end

endmodule

//--- src.f
cr_pkg.sv
cr_mem.sv
kbd_fifo.sv
vga_counter.sv
cr_top.sv
tb_cr_top.sv

//--- tb_cr_top.sv
// Random-stimulus testbench for cr_top; checks every output each cycle against a cycle model
`timescale 1ns/1ns

module tb_cr_top;
    import cr_pkg::*;

    // DUT runs with its default parameters
    localparam int KBD_DEPTH      = 4;
    localparam int H_TOTAL        = 800;
    localparam int V_TOTAL        = 525;
    localparam int HSYNC_LEN      = 96;
    localparam int VSYNC_LEN      = 2;
    localparam int RESET_CYCLES   = 16;
    // One full frame plus one line to cover vsync and the frame wrap
    localparam int NUM_CYCLES     = H_TOTAL * V_TOTAL + H_TOTAL;
    localparam int TIMEOUT_CYCLES = 2 * (RESET_CYCLES + NUM_CYCLES);
    // Board inputs packed as {joy_y, joy_x, switch, button_1, button_0}
    localparam int SYNC_W         = 2 + SWITCH_W + 2 * JOY_W;

    logic                   Clk;
    logic                   arst_n;
    logic [CR_DATA_W-1:0]   address;
    logic [CR_DATA_W-1:0]   data;
    logic                   wren;
    logic                   rden;
    logic [CR_DATA_W-1:0]   q;
    logic [CR_DATA_W-1:0]   address_b;
    logic [CR_DATA_W-1:0]   q_b;
    logic                   button_0;
    logic                   button_1;
    logic [SWITCH_W-1:0]    switch;
    logic [JOY_W-1:0]       joystick_x;
    logic [JOY_W-1:0]       joystick_y;
    logic [KBD_CODE_W-1:0]  kbd_code;
    logic                   kbd_valid;
    logic                   kbd_in_ready;
    logic [SEG7_W-1:0]      seg7_0, seg7_1, seg7_2, seg7_3, seg7_4, seg7_5;
    logic [LED_W-1:0]       led;
    logic                   hsync;
    logic                   vsync;

    // Model state named after the pipeline stage it stands for
    logic [SEG7_W-1:0]      m_seg7_wr [6];
    logic [SEG7_W-1:0]      m_seg7_p1 [6];
    logic [SEG7_W-1:0]      m_seg7_pin [6];
    logic [LED_W-1:0]       m_led_wr, m_led_p1, m_led_pin;
    logic                   m_scanf_en;
    logic [SYNC_W-1:0]      m_sync1, m_sync2;
    logic [VGA_POS_W-1:0]   m_vga_x_r, m_vga_y_r;
    logic [CR_DATA_W-1:0]   m_q, m_q_b;
    logic [KBD_CODE_W-1:0]  kq [$];
    int                     m_vga_cnt;
    logic                   kbd_hold;
    int                     y_reads;
    int                     cycle_cnt;
    integer                 seed;

    cr_top cr_top_inst (
        .Clk (Clk), .arst_n (arst_n),
        .address (address), .data (data), .wren (wren), .rden (rden), .q (q),
        .address_b (address_b), .q_b (q_b),
        .button_0 (button_0), .button_1 (button_1), .switch (switch),
        .joystick_x (joystick_x), .joystick_y (joystick_y),
        .kbd_code (kbd_code), .kbd_valid (kbd_valid), .kbd_in_ready (kbd_in_ready),
        .seg7_0 (seg7_0), .seg7_1 (seg7_1), .seg7_2 (seg7_2),
        .seg7_3 (seg7_3), .seg7_4 (seg7_4), .seg7_5 (seg7_5),
        .led (led), .hsync (hsync), .vsync (vsync)
    );

    initial begin
        Clk = 1'b0;
        forever #2 Clk = ~Clk;
    end

    // ----------------------------------------------------------------------
    // Failure reporting and typed compares
    // ----------------------------------------------------------------------
    task automatic report_failure(input string what);
        $display("%s", what);
        $display("Simulation failed");
        $fatal(1, "run stopped at first error");
    endtask

    task automatic check_word(input string name, input logic [CR_DATA_W-1:0] exp,
                              input logic [CR_DATA_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_seg7(input string name, input logic [SEG7_W-1:0] exp,
                              input logic [SEG7_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    task automatic check_led(input logic [LED_W-1:0] exp, input logic [LED_W-1:0] act);
        if (act !== exp)
            report_failure($sformatf("FAILED led expected 0x%h actual 0x%h", exp, act));
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        if (act !== exp)
            report_failure($sformatf("FAILED %s expected 0x%h actual 0x%h", name, exp, act));
    endtask

    // ----------------------------------------------------------------------
    // Model
    // ----------------------------------------------------------------------

    // Register map as the core sees it with outputs at the pin stage
    function automatic logic [CR_DATA_W-1:0] model_read(input logic [CR_DATA_W-1:0] addr);
        logic [CR_DATA_W-1:0] w;
        w = '0;
        case (addr)
            CR_SEG7_0, CR_SEG7_1, CR_SEG7_2,
            CR_SEG7_3, CR_SEG7_4, CR_SEG7_5 : w = CR_DATA_W'(m_seg7_pin[addr[4:2]]);
            CR_LED          : w = CR_DATA_W'(m_led_pin);
            CR_KBD_SCANF_EN : w = CR_DATA_W'(m_scanf_en);
            CR_BUTTON_0     : w = CR_DATA_W'(m_sync2[0]);
            CR_BUTTON_1     : w = CR_DATA_W'(m_sync2[1]);
            CR_SWITCH       : w = CR_DATA_W'(m_sync2[SWITCH_W+1:2]);
            CR_JOYSTICK_X   : w = CR_DATA_W'(m_sync2[JOY_W+SWITCH_W+1:SWITCH_W+2]);
            CR_JOYSTICK_Y   : w = CR_DATA_W'(m_sync2[SYNC_W-1:JOY_W+SWITCH_W+2]);
            CR_KBD_READY    : w = CR_DATA_W'(kq.size() > 0);
            CR_KBD_DATA     : w = (kq.size() > 0) ? CR_DATA_W'(kq[0]) : '0;
            CR_VGA_X        : w = CR_DATA_W'(m_vga_x_r);
            CR_VGA_Y        : w = CR_DATA_W'(m_vga_y_r);
            default         : w = '0;
        endcase
        return w;
    endfunction

    // Mostly mapped offsets with extra weight on the queue and some unmapped ones
    function automatic logic [CR_DATA_W-1:0] random_offset(input logic [31:0] r);
        logic [CR_DATA_W-1:0] a;
        case (r[3:0])
            4'd10        : a = CR_KBD_DATA;
            4'd11        : a = CR_KBD_SCANF_EN;
            // Small offsets that may be unaligned or past the map
            4'd12        : a = {26'd0, r[9:4]};
            4'd13, 4'd14 : a = {r[31:10] | 22'h1, r[9:0]};
            default      : a = int'(r[8:4]) % 17 * 4;
        endcase
        return a;
    endfunction

    // Advance the model over one rising edge
    // Reads see the state before the edge
    task automatic model_step();
        logic [CR_DATA_W-1:0] rd_q;
        logic                 pop;
        logic                 push;
        rd_q = rden ? model_read(address) : '0;
        m_q_b = model_read(address_b);
        if (rden && address == CR_VGA_Y && rd_q != '0)
            y_reads++;
        // Pop and push both decided on the old occupancy
        pop  = rden && (address == CR_KBD_DATA) && (kq.size() > 0);
        push = kbd_valid && m_scanf_en && (kq.size() < KBD_DEPTH);
        if (pop)
            void'(kq.pop_front());
        if (push)
            kq.push_back(kbd_code);
        kbd_hold = kbd_valid && !push;
        // Two output stages behind the written register
        for (int i = 0; i < 6; i++) begin
            m_seg7_pin[i] = m_seg7_p1[i];
            m_seg7_p1[i]  = m_seg7_wr[i];
        end
        m_led_pin = m_led_p1;
        m_led_p1  = m_led_wr;
        if (wren) begin
            case (address)
                CR_SEG7_0, CR_SEG7_1, CR_SEG7_2,
                CR_SEG7_3, CR_SEG7_4, CR_SEG7_5 : m_seg7_wr[address[4:2]] = data[SEG7_W-1:0];
                CR_LED          : m_led_wr   = data[LED_W-1:0];
                CR_KBD_SCANF_EN : m_scanf_en = data[0];
                default         : ;
            endcase
        end
        m_sync2 = m_sync1;
        m_sync1 = {joystick_y, joystick_x, switch, button_1, button_0};
        // Raster sampled from the count before this edge
        m_vga_x_r = VGA_POS_W'(m_vga_cnt % H_TOTAL);
        m_vga_y_r = VGA_POS_W'((m_vga_cnt / H_TOTAL) % V_TOTAL);
        m_vga_cnt++;
        m_q = rd_q;
    endtask

    // ----------------------------------------------------------------------
    // Stimulus and output checks
    // ----------------------------------------------------------------------
    task automatic drive_inputs();
        logic [31:0] r;
        r = $random(seed);
        wren = (r[1:0] == 2'b00);
        rden = (r[3:2] != 2'b00);
        r = $random(seed);
        address = random_offset(r);
        data = $random(seed);
        r = $random(seed);
        address_b = random_offset(r);
        r = $random(seed);
        button_0   = r[0];
        button_1   = r[1];
        switch     = r[SWITCH_W+1:2];
        joystick_x = r[JOY_W+SWITCH_W+1:SWITCH_W+2];
        r = $random(seed);
        joystick_y = r[JOY_W-1:0];
        // Source keeps an unaccepted code on the bus
        if (!kbd_hold) begin
            r = $random(seed);
            kbd_valid = r[0];
            kbd_code  = r[15:8];
        end
    endtask

    task automatic check_outputs();
        int x;
        int y;
        x = m_vga_cnt % H_TOTAL;
        y = (m_vga_cnt / H_TOTAL) % V_TOTAL;
        check_word("q", m_q, q);
        check_word("q_b", m_q_b, q_b);
        check_seg7("seg7_0", m_seg7_pin[0], seg7_0);
        check_seg7("seg7_1", m_seg7_pin[1], seg7_1);
        check_seg7("seg7_2", m_seg7_pin[2], seg7_2);
        check_seg7("seg7_3", m_seg7_pin[3], seg7_3);
        check_seg7("seg7_4", m_seg7_pin[4], seg7_4);
        check_seg7("seg7_5", m_seg7_pin[5], seg7_5);
        check_led(m_led_pin, led);
        check_bit("kbd_in_ready", m_scanf_en && (kq.size() < KBD_DEPTH), kbd_in_ready);
        // Sync idle high until the pulse length reaches the end of the line or frame
        check_bit("hsync", (x + HSYNC_LEN < H_TOTAL), hsync);
        check_bit("vsync", (y + VSYNC_LEN < V_TOTAL), vsync);
    endtask

    always @(posedge Clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES)
            report_failure("Timeout: the run went past its cycle limit");
    end

    initial begin
        seed = 32'h483c_61fb;
        arst_n = 1'b0;
        address = '0;
        data = '0;
        wren = 1'b0;
        rden = 1'b0;
        address_b = '0;
        button_0 = 1'b0;
        button_1 = 1'b0;
        switch = '0;
        joystick_x = '0;
        joystick_y = '0;
        kbd_code = '0;
        kbd_valid = 1'b0;
        for (int i = 0; i < 6; i++) begin
            m_seg7_wr[i]  = '0;
            m_seg7_p1[i]  = '0;
            m_seg7_pin[i] = '0;
        end
        m_led_wr = '0;
        m_led_p1 = '0;
        m_led_pin = '0;
        m_scanf_en = 1'b0;
        m_sync1 = '0;
        m_sync2 = '0;
        m_vga_x_r = '0;
        m_vga_y_r = '0;
        m_q = '0;
        m_q_b = '0;
        m_vga_cnt = 0;
        kbd_hold = 1'b0;
        y_reads = 0;
        repeat (RESET_CYCLES) @(negedge Clk);
        arst_n = 1'b1;
        check_outputs();
        for (int cyc = 0; cyc < NUM_CYCLES; cyc++) begin
            drive_inputs();
            model_step();
            @(negedge Clk);
            check_outputs();
        end
        if (y_reads == 0) begin
            report_failure("No raster line read happened after a horizontal wrap");
        end else begin
            $display("Simulation passed");
            $finish;
        end
    end

endmodule

//--- vga_counter.sv
// Raster position generator; feeds the VGA position registers and the sync pins
`timescale 1ns/1ns

module vga_counter #(
    parameter int H_TOTAL = 800,
    parameter int V_TOTAL = 525
) (
    input  logic                            Clk,
    input  logic                            arst_n,
    output logic [cr_pkg::VGA_POS_W-1:0]    vga_x,
    output logic [cr_pkg::VGA_POS_W-1:0]    vga_y,
    output logic                            hsync,
    output logic                            vsync
);
    import cr_pkg::*;

    // Sync pulse lengths at the end of the line and frame
    localparam int HSYNC_LEN = 96;
    localparam int VSYNC_LEN = 2;

    logic x_wrap;
    logic y_wrap;

    assign x_wrap = (vga_x == VGA_POS_W'(H_TOTAL - 1));
    assign y_wrap = (vga_y == VGA_POS_W'(V_TOTAL - 1));

    always_ff @(posedge Clk or negedge arst_n) begin
        if (!arst_n) begin
            vga_x <= '0;
            vga_y <= '0;
        end else begin
            vga_x <= x_wrap ? '0 : vga_x + 1'b1;
            // Line advances on the column wrap
            if (x_wrap) begin
                vga_y <= y_wrap ? '0 : vga_y + 1'b1;
            end
        end
    end

    // Active low, idle high at position 0
    assign hsync = !(vga_x >= VGA_POS_W'(H_TOTAL - HSYNC_LEN));
    assign vsync = !(vga_y >= VGA_POS_W'(V_TOTAL - VSYNC_LEN));

endmodule
